//--- sources.f
+incdir+include
source/hwpe_bus_pkg.sv
source/hwpe_engine_pkg.sv
source/hwpe_apb_demux.sv
source/hwpe_mem_mux.sv
source/vec_scale_engine.sv
source/sum_reduce_engine.sv
source/hwpe_subsystem.sv
tests/hwpe_subsystem_asserts.sv
tests/hwpe_subsystem_tb.sv

//--- tests/hwpe_subsystem_tb.sv
// Testbench of the accelerator subsystem: APB driver, memory model, reference results and checks
`timescale 1ns/1ns

module hwpe_subsystem_tb
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
();

  localparam int MEM_WORDS = 256;
  // Five jobs of at most 16 elements, near 5 cycles per element under stalls, plus APB
  // traffic and the 50-cycle hold stay far below this
  localparam int MAX_CYCLES = 20000;
  localparam int JOB_LIMIT  = 2000;

  logic        clk_i, rst_n_i, hwpe_en_i, evt, busy;
  engine_sel_t hwpe_sel_i;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  word_t       mem [MEM_WORDS];
  word_t       ref_mem [MEM_WORDS];
  logic [31:0] rng;
  int          cycles, errors, checks, tests, test_err0, evt_count, wr_grants, n0;
  logic        rd_hit;
  word_t       rd_word;

  hwpe_subsystem hwpe_subsystem_i (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .hwpe_en_i  ( hwpe_en_i  ),
    .hwpe_sel_i ( hwpe_sel_i ),
    .apb_req_i  ( apb_req    ),
    .apb_rsp_o  ( apb_rsp    ),
    .mem_req_o  ( mem_req    ),
    .mem_rsp_i  ( mem_rsp    ),
    .evt_o      ( evt        ),
    .busy_o     ( busy       )
  );

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Every address bit shows up in the word
  function automatic word_t fill_word(input int i);
    return (word_t'(i) * 32'h0101_0101) ^ 32'h5a00_0000;
  endfunction

  // Scale in PARAM[15:0], offset in PARAM[31:16], kept to the low 32 bits
  function automatic word_t scale_ref(input word_t x, input word_t param);
    logic [63:0] full;
    full = 64'(x) * 64'(param[15:0]) + 64'(param[31:16]);
    return full[31:0];
  endfunction

  function automatic word_t sum_ref(input int first, input int len);
    logic [63:0] total;
    total = '0;
    for (int i = 0; i < len; i++) total += 64'(ref_mem[first + i]);
    return total[31:0];
  endfunction

  function automatic addr_t reg_addr(input reg_idx_e r);
    return addr_t'({r, 2'b00});
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, random gnt, read data one cycle after the grant
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    rd_hit = 1'b0;
    if (rst_n_i && mem_req.req && mem_rsp.gnt) begin
      assert (mem_req.addr[31:10] == '0) else begin
        $display("Error at %0t ns: memory address %h outside the model", $time, mem_req.addr);
        errors++;
      end
      if (mem_req.we) begin
        mem[mem_req.addr[9:2]] = mem_req.wdata;
        wr_grants++;
      end else begin
        rd_hit  = 1'b1;
        rd_word = mem[mem_req.addr[9:2]];
      end
    end
    #10;
    rng            = lcg_next(rng);
    mem_rsp.gnt    = rng[16];
    mem_rsp.rvalid = rd_hit;
    mem_rsp.rdata  = rd_hit ? rd_word : '0;
  end

  // Done events and the run limit
  always @(posedge clk_i) begin
    if (rst_n_i && evt) evt_count++;
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Starts and ends 10 ns after a rising edge
  task automatic apb_xfer(input logic write, input addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk_i);
    #10 apb_req.penable = 1'b1;
    do @(posedge clk_i); while (!apb_rsp.pready);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    #10 apb_req = '0;
  endtask

  task automatic reg_write(input reg_idx_e r, input word_t d, input logic exp_err,
                           input string what);
    word_t rd;
    logic  err;
    apb_xfer(1'b1, reg_addr(r), d, rd, err);
    check_word({what, " write pslverr"}, word_t'(err), word_t'(exp_err));
  endtask

  task automatic reg_read(input reg_idx_e r, input word_t exp, input logic exp_err,
                          input string what);
    word_t rd;
    logic  err;
    apb_xfer(1'b0, reg_addr(r), '0, rd, err);
    check_word({what, " read pslverr"}, word_t'(err), word_t'(exp_err));
    if (!exp_err) check_word(what, rd, exp);
  endtask

  // PARAM only on the vector engine
  task automatic config_job(input addr_t src, input addr_t dst, input word_t len,
                            input word_t param);
    reg_write(REG_SRC, src, 1'b0, "SRC");
    reg_write(REG_DST, dst, 1'b0, "DST");
    reg_write(REG_LEN, len, 1'b0, "LEN");
    if (hwpe_sel_i == ENG_VEC) reg_write(REG_PARAM, param, 1'b0, "PARAM");
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!evt && n < JOB_LIMIT);
    assert (evt) else begin
      $display("Error at %0t ns: %s did not finish within %0d cycles", $time, what, JOB_LIMIT);
      errors++;
    end
    #10;
  endtask

  // Whole memory, the DST range scaled and everything else untouched
  task automatic check_vector(input int src_w, input int dst_w, input int len,
                              input word_t param);
    word_t exp;
    for (int i = 0; i < MEM_WORDS; i++) begin
      exp = ref_mem[i];
      if (i >= dst_w && i < dst_w + len) exp = scale_ref(ref_mem[src_w + i - dst_w], param);
      check_word($sformatf("mem[%0d]", i), mem[i], exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    hwpe_en_i  = 1'b1;
    hwpe_sel_i = ENG_VEC;
    apb_req    = '0;
    mem_rsp    = '0;
    rng        = 32'hfa5b;
    {cycles, errors, checks, tests, test_err0, evt_count, wr_grants} = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
    // Random operands of the sum job at words 128 to 143
    for (int i = 0; i < 16; i++) begin
      rng          = lcg_next(rng);
      mem[128 + i] = rng;
    end
    repeat (3) @(posedge clk_i);
    #10 rst_n_i = 1'b1;

    // Register access on each engine in turn
    for (int e = 0; e < 2; e++) begin
      hwpe_sel_i = engine_sel_t'(e);
      reg_write(REG_SRC, 32'h1004 * (e + 1), 1'b0, "SRC");
      reg_write(REG_DST, 32'h2008 * (e + 1), 1'b0, "DST");
      reg_write(REG_LEN, 32'h300c * (e + 1), 1'b0, "LEN");
      reg_write(REG_PARAM, 32'h4010, e == 1, "PARAM");
      reg_read(REG_SRC, 32'h1004 * (e + 1), 1'b0, "SRC");
      reg_read(REG_DST, 32'h2008 * (e + 1), 1'b0, "DST");
      reg_read(REG_LEN, 32'h300c * (e + 1), 1'b0, "LEN");
      reg_read(REG_PARAM, 32'h4010, e == 1, "PARAM");
      reg_read(REG_RESULT, '0, e == 0, "RESULT");
    end
    end_test("register access");

    // Scale 3, offset 7
    hwpe_sel_i = ENG_VEC;
    ref_mem    = mem;
    config_job(32'h000, 32'h100, 16, {16'd7, 16'd3});
    reg_write(REG_CTRL, 32'h1, 1'b0, "CTRL");
    wait_done("vector job");
    check_vector(0, 64, 16, {16'd7, 16'd3});
    reg_read(REG_STATUS, 32'h2, 1'b0, "vec STATUS");
    end_test("vector job");

    hwpe_sel_i = ENG_SUM;
    ref_mem    = mem;
    config_job(32'h200, 32'h300, 16, '0);
    reg_write(REG_CTRL, 32'h1, 1'b0, "CTRL");
    wait_done("sum job");
    check_word("sum at DST", mem[192], sum_ref(128, 16));
    reg_read(REG_RESULT, sum_ref(128, 16), 1'b0, "RESULT");
    // Empty vector into a nonzero word
    n0 = evt_count;
    config_job(32'h200, 32'h304, 0, '0);
    reg_write(REG_CTRL, 32'h1, 1'b0, "CTRL");
    wait_done("empty sum job");
    repeat (5) @(posedge clk_i);
    #10;
    check_word("empty sum at DST", mem[193], '0);
    check_word("evt pulses of empty job", word_t'(evt_count - n0), 32'd1);
    reg_read(REG_RESULT, '0, 1'b0, "empty RESULT");
    end_test("sum job");

    // Sum engine reconfigured while the vector job is parked
    hwpe_sel_i = ENG_VEC;
    ref_mem    = mem;
    config_job(32'h040, 32'h180, 16, {16'd1, 16'd5});
    reg_write(REG_CTRL, 32'h1, 1'b0, "CTRL");
    n0 = wr_grants;
    // Switch right after a granted write, no read in flight
    do begin
      @(posedge clk_i);
      #10;
    end while (wr_grants == n0 && cycles < MAX_CYCLES);
    hwpe_sel_i = ENG_SUM;
    config_job(32'h250, 32'h30c, 5, '0);
    hwpe_sel_i = ENG_VEC;
    #1;
    check_word("vec busy after reselect", word_t'(busy), 32'd1);
    wait_done("isolated vector job");
    check_vector(16, 96, 16, {16'd1, 16'd5});
    reg_read(REG_SRC, 32'h040, 1'b0, "vec SRC");
    reg_read(REG_PARAM, {16'd1, 16'd5}, 1'b0, "vec PARAM");
    hwpe_sel_i = ENG_SUM;
    reg_read(REG_SRC, 32'h250, 1'b0, "sum SRC");
    reg_read(REG_DST, 32'h30c, 1'b0, "sum DST");
    reg_read(REG_LEN, 32'd5, 1'b0, "sum LEN");
    end_test("engine isolation");

    // Enable dropped for 50 cycles mid-job
    hwpe_sel_i = ENG_VEC;
    ref_mem    = mem;
    config_job(32'h080, 32'h1c0, 16, {16'd9, 16'd2});
    reg_write(REG_CTRL, 32'h1, 1'b0, "CTRL");
    repeat (12) @(posedge clk_i);
    #10 hwpe_en_i = 1'b0;
    repeat (50) begin
      @(posedge clk_i);
      check_word("req while disabled", word_t'(mem_req.req), '0);
      check_word("busy while disabled", word_t'(busy), 32'd1);
    end
    #10 hwpe_en_i = 1'b1;
    wait_done("held vector job");
    check_vector(32, 112, 16, {16'd9, 16'd2});
    end_test("enable hold");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tests/hwpe_subsystem_asserts.sv
// Concurrent checks on the memory port and event outputs, bound into the subsystem top level
`timescale 1ns/1ns

module hwpe_subsystem_asserts
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        hwpe_en_i,
  input engine_sel_t hwpe_sel_i,
  input mem_req_t    mem_req_o,
  input mem_rsp_t    mem_rsp_i,
  input logic        evt_o,
  input logic        busy_o
);

  // Stalled request holds, unless the engine was disabled or deselected
  // Write data only matters for writes
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o.req && !mem_rsp_i.gnt |=>
      !hwpe_en_i || $changed(hwpe_sel_i) ||
      (mem_req_o.req && $stable(mem_req_o.we) && $stable(mem_req_o.addr) &&
       (!mem_req_o.we || $stable(mem_req_o.wdata))))
    else $error("memory request changed while gnt was low");

  // Disabled subsystem stays off the memory port
  req_off_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !hwpe_en_i |-> !mem_req_o.req)
    else $error("memory request while hwpe_en_i low");

  // Single-cycle done event
  evt_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_o |=> !evt_o)
    else $error("evt_o longer than one cycle");

  evt_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_o |-> !busy_o && $past(busy_o))
    else $error("evt_o without busy_o falling");

  // No read data without a granted read one cycle before
  rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.rvalid |-> $past(mem_req_o.req && !mem_req_o.we && mem_rsp_i.gnt))
    else $error("rvalid without a granted read");

endmodule

bind hwpe_subsystem hwpe_subsystem_asserts asserts_i (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .hwpe_en_i  ( hwpe_en_i  ),
  .hwpe_sel_i ( hwpe_sel_i ),
  .mem_req_o  ( mem_req_o  ),
  .mem_rsp_i  ( mem_rsp_i  ),
  .evt_o      ( evt_o      ),
  .busy_o     ( busy_o     )
);

//--- source/hwpe_subsystem.sv
// Top level of the accelerator: two engines sharing one APB target and one memory master
`timescale 1ns/1ns
`include "hwpe_config.svh"

module hwpe_subsystem
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        hwpe_en_i,
  input  engine_sel_t hwpe_sel_i,
  // Config port
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,
  // Shared memory port
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  // Done event and busy of the selected engine
  output logic        evt_o,
  output logic        busy_o
);

  logic     [`HWPE_N_ENGINES-1:0] eng_en, eng_busy, eng_evt;
  apb_req_t [`HWPE_N_ENGINES-1:0] eng_apb_req;
  apb_rsp_t [`HWPE_N_ENGINES-1:0] eng_apb_rsp;
  mem_req_t [`HWPE_N_ENGINES-1:0] eng_mem_req;
  mem_rsp_t [`HWPE_N_ENGINES-1:0] eng_mem_rsp;

  // Clock enable per engine, only the selected one runs
  for (genvar i = 0; i < `HWPE_N_ENGINES; i++) begin : gen_en
    assign eng_en[i] = hwpe_en_i && (hwpe_sel_i == engine_sel_t'(i));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Engines
  ////////////////////////////////////////////////////////////////////////////

  vec_scale_engine i_vec_scale_engine (
    .clk_i     ( clk_i                ),
    .rst_n_i   ( rst_n_i              ),
    .en_i      ( eng_en[ENG_VEC]      ),
    .apb_req_i ( eng_apb_req[ENG_VEC] ),
    .apb_rsp_o ( eng_apb_rsp[ENG_VEC] ),
    .mem_req_o ( eng_mem_req[ENG_VEC] ),
    .mem_rsp_i ( eng_mem_rsp[ENG_VEC] ),
    .busy_o    ( eng_busy[ENG_VEC]    ),
    .evt_o     ( eng_evt[ENG_VEC]     )
  );

  sum_reduce_engine i_sum_reduce_engine (
    .clk_i     ( clk_i                ),
    .rst_n_i   ( rst_n_i              ),
    .en_i      ( eng_en[ENG_SUM]      ),
    .apb_req_i ( eng_apb_req[ENG_SUM] ),
    .apb_rsp_o ( eng_apb_rsp[ENG_SUM] ),
    .mem_req_o ( eng_mem_req[ENG_SUM] ),
    .mem_rsp_i ( eng_mem_rsp[ENG_SUM] ),
    .busy_o    ( eng_busy[ENG_SUM]    ),
    .evt_o     ( eng_evt[ENG_SUM]     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shared ports
  ////////////////////////////////////////////////////////////////////////////

  hwpe_apb_demux i_hwpe_apb_demux (
    .sel_i     ( hwpe_sel_i  ),
    .apb_req_i ( apb_req_i   ),
    .apb_rsp_o ( apb_rsp_o   ),
    .eng_req_o ( eng_apb_req ),
    .eng_rsp_i ( eng_apb_rsp )
  );

  hwpe_mem_mux i_hwpe_mem_mux (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .sel_i     ( hwpe_sel_i  ),
    .eng_req_i ( eng_mem_req ),
    .eng_rsp_o ( eng_mem_rsp ),
    .mem_req_o ( mem_req_o   ),
    .mem_rsp_i ( mem_rsp_i   )
  );

  // Status of the selected engine
  assign evt_o  = eng_evt[hwpe_sel_i];
  assign busy_o = eng_busy[hwpe_sel_i];

endmodule

//--- source/sum_reduce_engine.sv
// Sum engine adding a vector of words and storing the total to memory and RESULT
`timescale 1ns/1ns
`include "hwpe_config.svh"

module sum_reduce_engine
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     busy_o,
  output logic     evt_o
);

  engine_state_e state_q, state_d;
  addr_t         src_q, dst_q;
  word_t         len_q, result_q, idx_q, acc_q;
  logic          done_q;
  reg_idx_e      reg_idx;
  logic          acc, map_hit, err, wr, start, step;
  word_t         rdata;

  ////////////////////////////////////////////////////////////////////////////
  // APB register access
  ////////////////////////////////////////////////////////////////////////////

  assign acc     = en_i & apb_req_i.psel & apb_req_i.penable;
  assign map_hit = (apb_req_i.paddr[`HWPE_ADDR_W-1:5] == '0) &&
                   (apb_req_i.paddr[1:0] == 2'b00);
  assign reg_idx = reg_idx_e'(apb_req_i.paddr[4:2]);

  always_comb begin
    rdata = '0;
    err   = !map_hit;
    case (reg_idx)
      REG_CTRL:   rdata = '0;
      REG_SRC:    rdata = src_q;
      REG_DST:    rdata = dst_q;
      REG_LEN:    rdata = len_q;
      // Read-only pair
      REG_STATUS: begin
        rdata = word_t'({done_q, busy_o});
        err   = err | apb_req_i.pwrite;
      end
      REG_RESULT: begin
        rdata = result_q;
        err   = err | apb_req_i.pwrite;
      end
      // PARAM and unused slot
      default:    err = 1'b1;
    endcase
  end

  assign wr    = acc & apb_req_i.pwrite & ~err;
  assign start = wr & (reg_idx == REG_CTRL) & apb_req_i.pwdata[0] & ~busy_o;

  assign apb_rsp_o.pready  = acc;
  assign apb_rsp_o.prdata  = (acc && !apb_req_i.pwrite && !err) ? rdata : '0;
  assign apb_rsp_o.pslverr = acc & err;

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM and accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        state_d = IDLE;
        // Empty vector still writes a zero sum
        if (start) state_d = (len_q == '0) ? WRITE : READ;
      end
      READ:      if (mem_rsp_i.gnt) state_d = WAIT_DATA;
      WAIT_DATA: if (mem_rsp_i.rvalid) state_d = (idx_q + 1 == len_q) ? WRITE : READ;
      WRITE:     if (mem_rsp_i.gnt) state_d = DONE;
      default:   state_d = IDLE;
    endcase
  end

  assign step = en_i | (state_q == WAIT_DATA);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      result_q <= '0;
      idx_q    <= '0;
      done_q   <= 1'b0;
    end else if (step) begin
      state_q <= state_d;
      if (wr && reg_idx == REG_SRC) src_q <= apb_req_i.pwdata;
      if (wr && reg_idx == REG_DST) dst_q <= apb_req_i.pwdata;
      if (wr && reg_idx == REG_LEN) len_q <= apb_req_i.pwdata;
      if (start) begin
        idx_q  <= '0;
        done_q <= 1'b0;
      end else if (state_q == WAIT_DATA && mem_rsp_i.rvalid) begin
        idx_q <= idx_q + 1;
      end
      // RESULT follows the granted write
      if (state_q == WRITE && mem_rsp_i.gnt) result_q <= acc_q;
      if (state_d == DONE) done_q <= 1'b1;
    end
  end

  // Running sum, modulo 2^32
  always_ff @(posedge clk_i) begin
    if (start) begin
      acc_q <= '0;
    end else if (state_q == WAIT_DATA && mem_rsp_i.rvalid) begin
      acc_q <= acc_q + mem_rsp_i.rdata;
    end
  end

  // Reads walk SRC, the single write goes to DST
  always_comb begin
    mem_req_o.req   = en_i && (state_q == READ || state_q == WRITE);
    mem_req_o.we    = (state_q == WRITE);
    mem_req_o.addr  = (state_q == WRITE) ? dst_q : src_q + {idx_q[`HWPE_ADDR_W-3:0], 2'b00};
    mem_req_o.wdata = acc_q;
  end

  assign busy_o = (state_q == READ) || (state_q == WAIT_DATA) || (state_q == WRITE);
  assign evt_o  = en_i && (state_q == DONE);

endmodule

//--- source/vec_scale_engine.sv
// Vector engine writing word times scale plus offset back to memory, configured over APB
`timescale 1ns/1ns
`include "hwpe_config.svh"

module vec_scale_engine
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     busy_o,
  output logic     evt_o
);

  engine_state_e state_q, state_d;
  addr_t         src_q, dst_q;
  // PARAM holds scale in [15:0], offset in [31:16]
  word_t         len_q, param_q, idx_q, data_q;
  logic          done_q;
  reg_idx_e      reg_idx;
  logic          acc, map_hit, err, wr, start, step;
  word_t         rdata, scaled;
  addr_t         offs;

  ////////////////////////////////////////////////////////////////////////////
  // APB register access
  ////////////////////////////////////////////////////////////////////////////

  // Access phase, only while enabled
  assign acc     = en_i & apb_req_i.psel & apb_req_i.penable;
  assign map_hit = (apb_req_i.paddr[`HWPE_ADDR_W-1:5] == '0) &&
                   (apb_req_i.paddr[1:0] == 2'b00);
  assign reg_idx = reg_idx_e'(apb_req_i.paddr[4:2]);

  always_comb begin
    rdata = '0;
    err   = !map_hit;
    case (reg_idx)
      // Write-only, reads zero
      REG_CTRL:   rdata = '0;
      REG_STATUS: begin
        rdata = word_t'({done_q, busy_o});
        err   = err | apb_req_i.pwrite;
      end
      REG_SRC:    rdata = src_q;
      REG_DST:    rdata = dst_q;
      REG_LEN:    rdata = len_q;
      REG_PARAM:  rdata = param_q;
      // RESULT and unused slot
      default:    err = 1'b1;
    endcase
  end

  assign wr    = acc & apb_req_i.pwrite & ~err;
  // Start only when no job is running
  assign start = wr & (reg_idx == REG_CTRL) & apb_req_i.pwdata[0] & ~busy_o;

  // Zero wait states
  assign apb_rsp_o.pready  = acc;
  assign apb_rsp_o.prdata  = (acc && !apb_req_i.pwrite && !err) ? rdata : '0;
  assign apb_rsp_o.pslverr = acc & err;

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        state_d = IDLE;
        // Empty vector finishes at once
        if (start) state_d = (len_q == '0) ? DONE : READ;
      end
      READ:      if (mem_rsp_i.gnt) state_d = WAIT_DATA;
      WAIT_DATA: if (mem_rsp_i.rvalid) state_d = WRITE;
      WRITE:     if (mem_rsp_i.gnt) state_d = (idx_q + 1 == len_q) ? DONE : READ;
      default:   state_d = IDLE;
    endcase
  end

  // Clock enable, a granted read still takes its data when disabled
  assign step = en_i | (state_q == WAIT_DATA);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      param_q <= '0;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else if (step) begin
      state_q <= state_d;
      if (wr && reg_idx == REG_SRC)   src_q   <= apb_req_i.pwdata;
      if (wr && reg_idx == REG_DST)   dst_q   <= apb_req_i.pwdata;
      if (wr && reg_idx == REG_LEN)   len_q   <= apb_req_i.pwdata;
      if (wr && reg_idx == REG_PARAM) param_q <= apb_req_i.pwdata;
      // Element counter
      if (start) begin
        idx_q  <= '0;
        done_q <= 1'b0;
      end else if (state_q == WRITE && mem_rsp_i.gnt) begin
        idx_q <= idx_q + 1;
      end
      // Sticky done, set on entry to DONE
      if (state_d == DONE) done_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath and memory port
  ////////////////////////////////////////////////////////////////////////////

  // Wraps modulo 2^32
  assign scaled = mem_rsp_i.rdata * word_t'(param_q[15:0]) + word_t'(param_q[31:16]);
  assign offs   = {idx_q[`HWPE_ADDR_W-3:0], 2'b00};

  // Result word for the next WRITE
  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_DATA && mem_rsp_i.rvalid) data_q <= scaled;
  end

  always_comb begin
    mem_req_o.req   = en_i && (state_q == READ || state_q == WRITE);
    mem_req_o.we    = (state_q == WRITE);
    mem_req_o.addr  = ((state_q == WRITE) ? dst_q : src_q) + offs;
    mem_req_o.wdata = data_q;
  end

  assign busy_o = (state_q == READ) || (state_q == WAIT_DATA) || (state_q == WRITE);
  // One pulse, held back while disabled
  assign evt_o  = en_i && (state_q == DONE);

endmodule

//--- source/hwpe_mem_mux.sv
// Static memory multiplexer joining the engine master ports onto the shared memory port
`timescale 1ns/1ns
`include "hwpe_config.svh"

module hwpe_mem_mux
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  engine_sel_t                       sel_i,
  // Engine side
  input  mem_req_t [`HWPE_N_ENGINES-1:0]    eng_req_i,
  output mem_rsp_t [`HWPE_N_ENGINES-1:0]    eng_rsp_o,
  // Shared memory side
  output mem_req_t                          mem_req_o,
  input  mem_rsp_t                          mem_rsp_i
);

  // Channel that issued the read in flight
  engine_sel_t rd_sel_q;

  // Request path follows the select directly
  assign mem_req_o = eng_req_i[sel_i];

  // Remember the reader so rvalid goes back to it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_sel_q <= '0;
    end else if (mem_req_o.req && !mem_req_o.we && mem_rsp_i.gnt) begin
      rd_sel_q <= sel_i;
    end
  end

  // Responses only to their owner, zeros elsewhere
  always_comb begin
    for (int i = 0; i < `HWPE_N_ENGINES; i++) begin
      eng_rsp_o[i] = '0;
      if (sel_i == engine_sel_t'(i)) begin
        eng_rsp_o[i].gnt = mem_rsp_i.gnt;
      end
      if (rd_sel_q == engine_sel_t'(i)) begin
        eng_rsp_o[i].rvalid = mem_rsp_i.rvalid;
        eng_rsp_o[i].rdata  = mem_rsp_i.rdata;
      end
    end
  end

endmodule

//--- source/hwpe_apb_demux.sv
// APB demultiplexer steering the config port to the engine named by the select input
`timescale 1ns/1ns
`include "hwpe_config.svh"

module hwpe_apb_demux
  import hwpe_bus_pkg::*;
  import hwpe_engine_pkg::*;
(
  // Engine select
  input  engine_sel_t                       sel_i,
  // Upstream APB target port
  input  apb_req_t                          apb_req_i,
  output apb_rsp_t                          apb_rsp_o,
  // One APB channel per engine
  output apb_req_t [`HWPE_N_ENGINES-1:0]    eng_req_o,
  input  apb_rsp_t [`HWPE_N_ENGINES-1:0]    eng_rsp_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `HWPE_N_ENGINES; i++) begin
      // Address, data and phase go to all engines
      eng_req_o[i] = apb_req_i;
      // Only the selected one sees psel
      eng_req_o[i].psel = apb_req_i.psel && (sel_i == engine_sel_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Idle bus returns zeros, never an old response
    apb_rsp_o = '0;
    if (apb_req_i.psel) begin
      apb_rsp_o = eng_rsp_i[sel_i];
    end
  end

endmodule

//--- source/hwpe_engine_pkg.sv
// Engine-level types: engine index, FSM states and register slots decoded by both engines
package hwpe_engine_pkg;

`include "hwpe_config.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Engine selection
  ////////////////////////////////////////////////////////////////////////////

  // Index of one engine behind the shared ports
  typedef logic [$clog2(`HWPE_N_ENGINES)-1:0] engine_sel_t;

  // Slot of each engine
  localparam engine_sel_t ENG_VEC = engine_sel_t'(0);
  localparam engine_sel_t ENG_SUM = engine_sel_t'(1);

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////////////////////

  // Common to both engines, DONE lasts one cycle
  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_DATA,
    WRITE,
    DONE
  } engine_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Register slots
  ////////////////////////////////////////////////////////////////////////////

  // Word index of each register, taken from paddr[4:2]
  typedef enum logic [2:0] {
    REG_CTRL   = 3'(`HWPE_REG_CTRL >> 2),
    REG_STATUS = 3'(`HWPE_REG_STATUS >> 2),
    REG_SRC    = 3'(`HWPE_REG_SRC >> 2),
    REG_DST    = 3'(`HWPE_REG_DST >> 2),
    REG_LEN    = 3'(`HWPE_REG_LEN >> 2),
    REG_PARAM  = 3'(`HWPE_REG_PARAM >> 2),
    REG_RESULT = 3'(`HWPE_REG_RESULT >> 2)
  } reg_idx_e;

endpackage

//--- source/hwpe_bus_pkg.sv
// Bus-level types shared by RTL and testbench: words, addresses, APB and memory port structs
package hwpe_bus_pkg;

`include "hwpe_config.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////////////////////////////////////////

  // One data word
  typedef logic [`HWPE_DATA_W-1:0] word_t;
  // Byte address on APB and memory
  typedef logic [`HWPE_ADDR_W-1:0] addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // APB target port
  ////////////////////////////////////////////////////////////////////////////

  // Requester side
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
  } apb_req_t;

  // Completer side, pready marks the last access cycle
  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // Memory master port
  ////////////////////////////////////////////////////////////////////////////

  // Held stable until gnt
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // rvalid one cycle after a granted read
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

endpackage

//--- include/hwpe_config.svh
// Widths, engine count and register byte offsets, included by packages and RTL
`ifndef HWPE_CONFIG_SVH
`define HWPE_CONFIG_SVH

// Data word and byte address widths
`define HWPE_DATA_W 32
`define HWPE_ADDR_W 32

// Engines behind the shared ports
`define HWPE_N_ENGINES 2

// Register map, byte offsets from the APB window base
// Write-only, bit 0 starts a job
`define HWPE_REG_CTRL 32'h00
// Bit 0 busy, bit 1 sticky done
`define HWPE_REG_STATUS 32'h04
`define HWPE_REG_SRC 32'h08
`define HWPE_REG_DST 32'h0c
// Element count
`define HWPE_REG_LEN 32'h10
// Vector engine only
`define HWPE_REG_PARAM 32'h14
// Sum engine only, read-only
`define HWPE_REG_RESULT 32'h18

`endif
